//--- bench/icache_checker.sv
`timescale 1ns/100ps

module icache_checker import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  logic  req_ready,
    input  addr_t req_address,
    input  logic  dp_valid,
    input  logic  dp_ready,
    input  line_t dp_read_data,
    input  logic  tlb_hit,
    input  logic  mem_req,
    input  addr_t mem_addr,
    input  logic  mem_data_valid,
    input  logic  grant_in,
    input  logic  grant_out,
    input  logic  bus_busy_in,
    input  logic  bus_busy_out,
    input  logic  exp_hit,
    input  int    tlb_delay,
    output int    error_count,
    output int    test_count
);

    logic  active;
    logic  hit_q;
    logic  saw_req;
    logic  seen_valid;
    int    delay_q;
    int    cycles;
    int    strobes;
    int    test_errors;
    addr_t line_base;
    addr_t fetch_addr;

    // each word holds its own physical address xor c0de0000
    function automatic line_t expected_line(input addr_t base);
        line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = (base + addr_t'(4 * w)) ^ 32'hc0de_0000;
        end
        return line;
    endfunction

    task automatic flag_value(input string name, input line_t expected, input line_t actual);
        $display("error %s expected %0h actual %0h", name, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic flag_event(input string what);
        $display("%s", what);
        error_count++;
        test_errors++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            error_count = 0;
            test_count = 0;
            active = 1'b0;
        end else begin
            if (grant_out !== (grant_in && !mem_req)) begin
                flag_value("grant_out", line_t'(grant_in && !mem_req), line_t'(grant_out));
            end
            if (bus_busy_out && bus_busy_in) begin
                flag_event("bus_busy_out rose while another master held the bus");
            end
            if (active) begin
                cycles++;
                if (mem_req) begin
                    saw_req = 1'b1;
                end
                if (!tlb_hit && (mem_req || dp_valid)) begin
                    flag_event("mem_req or dp_valid rose before the TLB translated");
                end
                if (mem_data_valid) begin
                    if (!bus_busy_out) begin
                        flag_event("a strobe arrived while the cache did not own the bus");
                    end
                    if (mem_addr !== line_base + addr_t'(4 * strobes)) begin
                        flag_value("mem_addr", line_t'(line_base + addr_t'(4 * strobes)),
                            line_t'(mem_addr));
                    end
                    strobes++;
                end
                if (dp_valid) begin
                    // rises 2 cycles after accept and shows up here one edge later
                    if (!seen_valid && hit_q && cycles != delay_q + 3) begin
                        flag_event($sformatf("hit response came %0d cycles after accept, not %0d",
                            cycles - 1, delay_q + 2));
                    end
                    seen_valid = 1'b1;
                    if (dp_read_data !== expected_line(line_base)) begin
                        flag_value("dp_read_data", expected_line(line_base), dp_read_data);
                    end
                    if (req_ready) begin
                        flag_value("req_ready", line_t'(1'b0), line_t'(req_ready));
                    end
                    if (dp_ready) begin
                        if (saw_req == hit_q) begin
                            flag_value("mem_req", line_t'(!hit_q), line_t'(saw_req));
                        end
                        if (!hit_q && strobes != 4) begin
                            flag_event($sformatf("refill took %0d strobes instead of 4", strobes));
                        end
                        if (test_errors == 0) begin
                            $display("fetch %0d at %h passed", test_count, fetch_addr);
                        end else begin
                            $display("fetch %0d at %h had %0d errors", test_count, fetch_addr,
                                test_errors);
                        end
                        test_count++;
                        active = 1'b0;
                    end
                end
            end
            if (req_valid && req_ready) begin
                active = 1'b1;
                hit_q = exp_hit;
                delay_q = tlb_delay;
                saw_req = 1'b0;
                seen_valid = 1'b0;
                cycles = 0;
                strobes = 0;
                test_errors = 0;
                fetch_addr = req_address;
                // same TLB mapping as the bench model
                line_base = (req_address ^ 32'h8000_0000) & 32'hffff_fff0;
            end
        end
    end

endmodule

//--- bench/icache_tb.sv
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

    localparam int max_vectors = 64;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    addr_t req_address;
    logic  dp_ready;
    addr_t phys_addr;
    logic  tlb_hit;
    logic  mem_data_valid;
    word_t mem_data;
    logic  grant_in;
    logic  bus_busy_in;
    logic  req_ready;
    logic  dp_valid;
    line_t dp_read_data;
    addr_t mem_addr;
    logic  mem_req;
    logic  grant_out;
    logic  bus_busy_out;

    logic [63:0] vectors [max_vectors];
    int          num_vectors;
    int          timeout_limit = 0;
    int          cycle_count = 0;
    int          busy_cycles = 0;
    int          tlb_delay = 0;
    logic        exp_hit = 1'b0;
    logic [31:0] stall_rng = 32'h65a8_5e7a;
    int          error_count;
    int          test_count;

    tb_clock i_clock (.clk(clk));

    icache i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_address    (req_address),
        .dp_ready       (dp_ready),
        .phys_addr      (phys_addr),
        .tlb_hit        (tlb_hit),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .grant_in       (grant_in),
        .bus_busy_in    (bus_busy_in),
        .req_ready      (req_ready),
        .dp_valid       (dp_valid),
        .dp_read_data   (dp_read_data),
        .mem_addr       (mem_addr),
        .mem_req        (mem_req),
        .grant_out      (grant_out),
        .bus_busy_out   (bus_busy_out)
    );

    icache_checker i_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_address    (req_address),
        .dp_valid       (dp_valid),
        .dp_ready       (dp_ready),
        .dp_read_data   (dp_read_data),
        .tlb_hit        (tlb_hit),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data_valid (mem_data_valid),
        .grant_in       (grant_in),
        .grant_out      (grant_out),
        .bus_busy_in    (bus_busy_in),
        .bus_busy_out   (bus_busy_out),
        .exp_hit        (exp_hit),
        .tlb_delay      (tlb_delay),
        .error_count    (error_count),
        .test_count     (test_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // one fetch entered and left on a falling edge
    task automatic run_fetch(input logic [63:0] vec);
        addr_t address;
        address = vec[63:32];
        tlb_delay = int'(vec[31:24]);
        busy_cycles = int'(vec[15:8]);
        exp_hit = vec[0];
        req_address = address;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        // TLB model flips bit 31
        phys_addr = address ^ 32'h8000_0000;
        repeat (tlb_delay) @(negedge clk);
        tlb_hit = 1'b1;
        while (!dp_valid) @(negedge clk);
        if (vec[16]) begin
            stall_rng = xorshift(stall_rng);
            repeat (stall_rng % 32'd4 + 32'd1) @(negedge clk);
        end
        dp_ready = 1'b1;
        @(negedge clk);
        dp_ready = 1'b0;
        tlb_hit = 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_address = '0;
        dp_ready = 1'b0;
        phys_addr = '0;
        tlb_hit = 1'b0;
        for (int i = 0; i < max_vectors; i++) begin
            vectors[i] = '1;
        end
        $readmemh("bench/icache_vectors.txt", vectors);
        num_vectors = 0;
        while (num_vectors < max_vectors && vectors[num_vectors] != '1) begin
            num_vectors++;
        end
        timeout_limit = 80 * num_vectors + 20;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_vectors; i++) begin
            run_fetch(vectors[i]);
        end
        repeat (2) @(negedge clk);
        $display("%0d of %0d fetches checked, %0d errors", test_count, num_vectors, error_count);
        if (error_count == 0 && test_count == num_vectors) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // memory, arbiter chain and other masters
    initial begin : bus_model
        logic [31:0] bus_rng;
        bus_rng = 32'h65a8_5e7a;
        grant_in = 1'b0;
        bus_busy_in = 1'b0;
        mem_data_valid = 1'b0;
        mem_data = '0;
        forever begin
            @(negedge clk);
            if (!mem_req) begin
                // token toggles past an idle node
                grant_in = ~grant_in;
            end else begin
                // grant arrives while someone else still holds the bus
                grant_in = (busy_cycles != 0);
                bus_busy_in = (busy_cycles != 0);
                repeat (busy_cycles) @(negedge clk);
                bus_busy_in = 1'b0;
                grant_in = 1'b0;
                bus_rng = xorshift(bus_rng);
                repeat (bus_rng % 32'd4) @(negedge clk);
                grant_in = 1'b1;
                @(negedge clk);
                for (int k = 0; k < 4; k++) begin
                    bus_rng = xorshift(bus_rng);
                    repeat (bus_rng % 32'd3) @(negedge clk);
                    mem_data_valid = 1'b1;
                    mem_data = mem_addr ^ 32'hc0de_0000;
                    @(negedge clk);
                    mem_data_valid = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (timeout_limit != 0 && cycle_count >= timeout_limit);
        $display("timeout, the run did not finish within %0d cycles", timeout_limit);
        $display("Test failed");
        $finish;
    end

endmodule

//--- bench/icache_vectors.txt
// one fetch per line, 64 bits in hex
// address[63:32] tlb_delay[31:24] stall[23:16] bus_busy_cycles[15:8] expected_hit[7:0]
0000100000000000
0000100400000001
0000100803000001
0000300000000000
0000100000000200
0000204002010000
0000204c00010001
0000510000000600
0000510401000001
000001f004000000
000001f800010001
0000300800000000
0000100000000300
0000100c00010001

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

//--- design/icache.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  addr_t req_address,
    input  logic  dp_ready,
    input  addr_t phys_addr,
    input  logic  tlb_hit,
    input  logic  mem_data_valid,
    input  word_t mem_data,
    input  logic  grant_in,
    input  logic  bus_busy_in,
    output logic  req_ready,
    output logic  dp_valid,
    output line_t dp_read_data,
    output addr_t mem_addr,
    output logic  mem_req,
    output logic  grant_out,
    output logic  bus_busy_out
);

    index_t index_q;
    tag_t   phys_tag;
    line_t  read_line;
    line_t  fill_line;

    logic cache_hit;
    logic array_write;
    logic fill_start;
    logic fill_done;
    logic pa_load;
    logic grant_pass;

    // set index from the virtual address at acceptance
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            index_q <= req_address[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        end
    end

    assign phys_tag = phys_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    icache_arrays i_arrays (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (index_q),
        .write      (array_write),
        .write_tag  (phys_tag),
        .write_line (fill_line),
        .lookup_tag (phys_tag),
        .read_line  (read_line),
        .cache_hit  (cache_hit)
    );

    icache_controller i_controller (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .dp_ready     (dp_ready),
        .tlb_hit      (tlb_hit),
        .cache_hit    (cache_hit),
        .grant_in     (grant_in),
        .bus_busy_in  (bus_busy_in),
        .fill_done    (fill_done),
        .req_ready    (req_ready),
        .dp_valid     (dp_valid),
        .pa_load      (pa_load),
        .fill_start   (fill_start),
        .array_write  (array_write),
        .mem_req      (mem_req),
        .bus_busy_out (bus_busy_out),
        .grant_pass   (grant_pass)
    );

    line_fill i_line_fill (
        .clk            (clk),
        .rst_n          (rst_n),
        .pa_load        (pa_load),
        .phys_addr      (phys_addr),
        .fill_start     (fill_start),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .mem_addr       (mem_addr),
        .fill_line      (fill_line),
        .fill_done      (fill_done)
    );

    // daisy chained grant blocked while we request or own the bus
    assign grant_out = grant_in && grant_pass;

    assign dp_read_data = read_line;

endmodule

//--- design/icache_arrays.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_arrays import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  index_t index,
    input  logic   write,
    input  tag_t   write_tag,
    input  line_t  write_line,
    input  tag_t   lookup_tag,
    output line_t  read_line,
    output logic   cache_hit
);

    tag_t  tag_mem  [`ICACHE_LINES];
    line_t data_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_q;

    tag_t stored_tag;
    logic stored_valid;

    // reset invalidates every line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (write) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            tag_mem[index]  <= write_tag;
            data_mem[index] <= write_line;
        end
    end

    // combinational read at the latched index
    assign stored_tag   = tag_mem[index];
    assign stored_valid = valid_q[index];
    assign read_line    = data_mem[index];

    // full physical tag compare
    assign cache_hit = stored_valid && (stored_tag == lookup_tag);

endmodule

//--- design/icache_controller.sv
`timescale 1ns/100ps

module icache_controller import icache_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    input  logic dp_ready,
    input  logic tlb_hit,
    input  logic cache_hit,
    input  logic grant_in,
    input  logic bus_busy_in,
    input  logic fill_done,
    output logic req_ready,
    output logic dp_valid,
    output logic pa_load,
    output logic fill_start,
    output logic array_write,
    output logic mem_req,
    output logic bus_busy_out,
    output logic grant_pass
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic bus_won;

    // grant reaches us and nobody upstream holds the bus
    assign bus_won = grant_in && !bus_busy_in;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req_valid) begin
                    state_d = st_translate;
                end
            end
            // wait here as long as the TLB has no translation
            st_translate: begin
                if (tlb_hit) begin
                    state_d = st_compare;
                end
            end
            st_compare: begin
                if (cache_hit) begin
                    state_d = st_respond;
                end else begin
                    state_d = st_bus_wait;
                end
            end
            st_bus_wait: begin
                if (bus_won) begin
                    state_d = st_fill;
                end
            end
            st_fill: begin
                if (fill_done) begin
                    state_d = st_write;
                end
            end
            st_write: begin
                state_d = st_respond;
            end
            st_respond: begin
                if (dp_ready) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    assign req_ready = (state_q == st_idle);
    assign dp_valid  = (state_q == st_respond);

    // capture the line-aligned physical address once translated
    assign pa_load = (state_q == st_translate) && tlb_hit;

    // restart the word counter on the way into a refill
    assign fill_start = (state_q == st_compare) && !cache_hit;

    assign array_write = (state_q == st_write);

    // request held through arbitration and the burst
    assign mem_req = (state_q == st_bus_wait) || (state_q == st_fill);

    // ownership begins on the winning cycle itself
    assign bus_busy_out = (state_q == st_fill) || ((state_q == st_bus_wait) && bus_won);

    assign grant_pass = (state_q != st_bus_wait) && (state_q != st_fill);

endmodule

//--- design/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_LINES 32
`define ICACHE_INDEX_W 5
`define ICACHE_OFFSET_W 4
`define ICACHE_TAG_W 23

// address and data widths
`define ICACHE_ADDR_W 32
`define ICACHE_BUS_W 32
`define ICACHE_LINE_W 128

// bus words per cache line
`define ICACHE_WORDS 4

`endif

//--- design/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    // virtual or physical byte address
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    // address bits 31..9 and 8..4
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    typedef logic [`ICACHE_BUS_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic [$clog2(`ICACHE_WORDS)-1:0] word_sel_t;

    typedef enum logic [2:0] {
        st_idle,
        st_translate,
        st_compare,
        st_bus_wait,
        st_fill,
        st_write,
        st_respond
    } ctrl_state_t;

endpackage

//--- design/line_fill.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module line_fill import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pa_load,
    input  addr_t phys_addr,
    input  logic  fill_start,
    input  logic  mem_data_valid,
    input  word_t mem_data,
    output addr_t mem_addr,
    output line_t fill_line,
    output logic  fill_done
);

    addr_t     addr_q;
    word_sel_t word_cnt;
    line_t     accum_q;

    // line aligned bus word address
    always_ff @(posedge clk) begin
        if (pa_load) begin
            addr_q <= {phys_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], `ICACHE_OFFSET_W'(0)};
        end else if (mem_data_valid) begin
            addr_q <= addr_q + addr_t'(`ICACHE_BUS_W / 8);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (fill_start) begin
            word_cnt <= '0;
        end else if (mem_data_valid) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // each strobe lands in its own quarter
    always_ff @(posedge clk) begin
        if (mem_data_valid) begin
            accum_q[word_cnt * `ICACHE_BUS_W +: `ICACHE_BUS_W] <= mem_data;
        end
    end

    assign fill_done = mem_data_valid && (word_cnt == word_sel_t'(`ICACHE_WORDS - 1));

    // last word bypasses the register on the closing strobe
    assign fill_line = {
        fill_done ? mem_data : accum_q[`ICACHE_LINE_W-1 -: `ICACHE_BUS_W],
        accum_q[`ICACHE_LINE_W-`ICACHE_BUS_W-1:0]
    };

    assign mem_addr = addr_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sim.f --top-module icache_tb -o icache_sim

if ./obj_dir/icache_sim | tee /dev/stderr | grep -Fx "Test completed successfully" > /dev/null; then
    exit 0
else
    exit 1
fi

//--- sim.f
+incdir+design
design/icache_pkg.sv
design/icache_arrays.sv
design/icache_controller.sv
design/line_fill.sv
design/icache.sv
bench/tb_clock.sv
bench/icache_checker.sv
bench/icache_tb.sv
